// File: verilog.f
uart_pkg.sv
rx_frame_if.sv
baud_gen.sv
line_config.sv
uart_tx.sv
uart_rx.sv
rx_display.sv
uart_loopback.sv
tb_clock_gen.sv
uart_loopback_properties.sv
tb_uart_loopback.sv

// File: tb_uart_loopback.sv
`default_nettype none

module tb_uart_loopback;

  import uart_pkg::*;

  localparam int CLKS_PER_TICK = 4;
  localparam int FRAMES_8N1    = 8;
  localparam int FRAMES_7N1    = 6;
  localparam int FRAMES_PARITY = 6;  // per parity mode
  localparam int NUM_FRAMES    = FRAMES_8N1 + FRAMES_7N1 + 2 * FRAMES_PARITY;
  localparam int FRAME_CLKS    = 12 * 16 * CLKS_PER_TICK;  // longest frame
  localparam int WATCHDOG_TIME = 2 * NUM_FRAMES * FRAME_CLKS * 8;

  logic       clk;
  logic       reset;
  logic       tx_req;
  logic [7:0] tx_data;
  logic       data_bits8;
  parity_e    parity_mode;
  logic       two_stop;
  logic       tx_ack;
  logic       serial_line;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic       parity_error;
  logic       stop_error;
  seg_t       seg_ones;
  seg_t       seg_tens;
  seg_t       seg_hundreds;

  int   checks;
  int   errors;
  int   tests;
  seg_t digit_segs [10];

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(10)) u_clk (.clk(clk), .reset(reset));

  uart_loopback #(.CLKS_PER_TICK(CLKS_PER_TICK)) uut (
    .clk(clk), .reset(reset), .tx_req(tx_req), .tx_data(tx_data),
    .data_bits8(data_bits8), .parity_mode(parity_mode), .two_stop(two_stop),
    .tx_ack(tx_ack), .serial_line(serial_line), .rx_valid(rx_valid), .rx_data(rx_data),
    .parity_error(parity_error), .stop_error(stop_error),
    .seg_ones(seg_ones), .seg_tens(seg_tens), .seg_hundreds(seg_hundreds)
  );

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("FAILED %s expected 0x%02h got 0x%02h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_true(input string problem, input logic ok);
    checks++;
    assert (ok === 1'b1)
    else
    begin
      $display("ERROR: %s", problem);
      errors++;
    end
  endtask

  task automatic check_display(input logic [7:0] value);
    check_value("seg_hundreds", {1'b0, digit_segs[value / 100]}, {1'b0, seg_hundreds});
    check_value("seg_tens", {1'b0, digit_segs[(value / 10) % 10]}, {1'b0, seg_tens});
    check_value("seg_ones", {1'b0, digit_segs[value % 10]}, {1'b0, seg_ones});
  endtask

  // called on a falling edge, returns on one
  task automatic send_and_check(input logic [7:0] value);
    int         cycles;
    logic [7:0] expected;
    expected = data_bits8 ? value : {1'b0, value[6:0]};
    tx_data  = value;
    tx_req   = 1'b1;
    cycles   = 0;
    while (!tx_ack && cycles < 2 * FRAME_CLKS)  // waits out the previous frame
    begin
      @(negedge clk);
      cycles++;
    end
    expect_true("tx_ack did not rise after tx_req", tx_ack);
    tx_req = 1'b0;
    cycles = 0;
    while (!rx_valid && cycles < 2 * FRAME_CLKS)
    begin
      @(negedge clk);
      cycles++;
    end
    expect_true("rx_valid did not pulse within two frame times", rx_valid);
    expect_true("tx_ack stayed high after tx_req dropped", !tx_ack);
    @(negedge clk);  // display registers on the clock after rx_valid
    check_value("rx_data", expected, rx_data);
    check_value("parity_error", 8'h00, {7'b0, parity_error});
    check_value("stop_error", 8'h00, {7'b0, stop_error});
    check_display(expected);
  endtask

  task automatic run_frames(input string name, input int count);
    int          errors_before;
    int          checks_before;
    logic [31:0] word;
    errors_before = errors;
    checks_before = checks;
    for (int i = 0; i < count; i++)
    begin
      word = $urandom;
      send_and_check(word[7:0]);
    end
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - checks_before,
             errors - errors_before);
  endtask

  // only between frames; line_config holds it while busy anyway
  task automatic set_format(input logic bits8, input parity_e par, input logic stop2);
    data_bits8  = bits8;
    parity_mode = par;
    two_stop    = stop2;
  endtask

  initial
  begin
    int errors_before;
    tx_req      = 1'b0;
    tx_data     = 8'h00;
    data_bits8  = 1'b1;
    parity_mode = PAR_NONE;
    two_stop    = 1'b0;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    void'($urandom(32'h6e87));
    digit_segs[0] = 7'b1111110;
    digit_segs[1] = 7'b0110000;
    digit_segs[2] = 7'b1101101;
    digit_segs[3] = 7'b1111001;
    digit_segs[4] = 7'b0110011;
    digit_segs[5] = 7'b1011011;
    digit_segs[6] = 7'b0011111;  // 6 drawn without the top bar
    digit_segs[7] = 7'b1110000;
    digit_segs[8] = 7'b1111111;
    digit_segs[9] = 7'b1111011;

    @(negedge reset);
    @(negedge clk);
    errors_before = errors;
    check_value("tx_ack", 8'h00, {7'b0, tx_ack});
    check_value("rx_valid", 8'h00, {7'b0, rx_valid});
    check_value("serial_line", 8'h01, {7'b0, serial_line});
    check_value("rx_data", 8'h00, rx_data);
    check_display(8'd0);
    tests++;
    $display("test reset state: %0d errors", errors - errors_before);

    run_frames("8N1 round trip", FRAMES_8N1);
    set_format(1'b0, PAR_NONE, 1'b0);
    run_frames("7-bit mode", FRAMES_7N1);
    set_format(1'b1, PAR_ODD, 1'b1);
    run_frames("odd parity two stop", FRAMES_PARITY);
    set_format(1'b1, PAR_EVEN, 1'b1);
    run_frames("even parity two stop", FRAMES_PARITY);

    tests++;
    errors = errors + uut.u_props.failures;
    $display("test handshake properties: %0d failures", uut.u_props.failures);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_TIME);
    $display("timeout: run did not finish within %0d time units", WATCHDOG_TIME);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_loopback_properties.sv
`default_nettype none

module uart_loopback_properties (
  input logic clk,
  input logic reset,
  input logic tx_req,
  input logic tx_ack,
  input logic tx_busy,
  input logic rx_valid,
  input logic serial_line
);

  int   failures = 0;  // read by the testbench
  logic ack_d;
  logic frame_open;    // acked frame not yet seen by the receiver

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ack_d      <= 1'b0;
      frame_open <= 1'b0;
    end
    else
    begin
      ack_d <= tx_ack;
      if (tx_ack && !ack_d)
        frame_open <= 1'b1;
      else if (rx_valid)
        frame_open <= 1'b0;
    end
  end

  ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_ack) |-> $past(tx_req))
  else
  begin
    $error("tx_ack rose without tx_req high");
    failures++;
  end

  ack_fall_without_req: assert property (@(posedge clk) disable iff (reset)
    $fell(tx_ack) |-> !$past(tx_req))
  else
  begin
    $error("tx_ack fell while tx_req was still high");
    failures++;
  end

  // next ack only once the previous frame has gone through its stop bits
  ack_after_frame: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_ack) |-> !frame_open)
  else
  begin
    $error("tx_ack rose before the previous frame was received");
    failures++;
  end

  valid_single_cycle: assert property (@(posedge clk) disable iff (reset)
    rx_valid |=> !rx_valid)
  else
  begin
    $error("rx_valid high on two consecutive cycles");
    failures++;
  end

  line_idles_high: assert property (@(posedge clk) disable iff (reset)
    !tx_busy |-> serial_line)
  else
  begin
    $error("serial_line low while the transmitter is idle");
    failures++;
  end

endmodule

bind uart_loopback uart_loopback_properties u_props (
  .clk(clk), .reset(reset), .tx_req(tx_req), .tx_ack(tx_ack), .tx_busy(tx_busy),
  .rx_valid(rx_valid), .serial_line(serial_line)
);

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release on a falling edge, like the rest of the stimulus
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: uart_loopback.sv
`default_nettype none

module uart_loopback #(
  parameter int CLKS_PER_TICK = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              tx_req,
  input  logic [7:0]        tx_data,
  input  logic              data_bits8,
  input  uart_pkg::parity_e parity_mode,
  input  logic              two_stop,
  output logic              tx_ack,
  output logic              serial_line,
  output logic              rx_valid,
  output logic [7:0]        rx_data,
  output logic              parity_error,
  output logic              stop_error,
  output uart_pkg::seg_t    seg_ones,
  output uart_pkg::seg_t    seg_tens,
  output uart_pkg::seg_t    seg_hundreds
);

  import uart_pkg::*;

  frame_cfg_t cfg;
  logic       os_tick;
  logic       tx_busy;
  logic       rx_busy;

  rx_frame_if frame_bus ();

  assign rx_valid = frame_bus.valid;  // unregistered

  baud_gen #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_baud (
    .clk(clk), .reset(reset), .os_tick(os_tick)
  );

  line_config u_cfg (
    .clk(clk), .reset(reset), .data_bits8(data_bits8), .parity_mode(parity_mode),
    .two_stop(two_stop), .tx_busy(tx_busy), .rx_busy(rx_busy), .cfg(cfg)
  );

  uart_tx u_tx (
    .clk(clk), .reset(reset), .os_tick(os_tick), .cfg(cfg), .tx_req(tx_req),
    .tx_data(tx_data), .tx_ack(tx_ack), .tx_busy(tx_busy), .serial_line(serial_line)
  );

  // loopback path
  uart_rx u_rx (
    .clk(clk), .reset(reset), .os_tick(os_tick), .cfg(cfg), .serial_line(serial_line),
    .rx_busy(rx_busy), .frame(frame_bus.source)
  );

  rx_display u_disp (
    .clk(clk), .reset(reset), .frame(frame_bus.sink), .rx_data(rx_data),
    .parity_error(parity_error), .stop_error(stop_error),
    .seg_ones(seg_ones), .seg_tens(seg_tens), .seg_hundreds(seg_hundreds)
  );

endmodule

`default_nettype wire

// File: rx_display.sv
`default_nettype none

module rx_display (
  input  logic           clk,
  input  logic           reset,
  rx_frame_if.sink       frame,
  output logic [7:0]     rx_data,
  output logic           parity_error,
  output logic           stop_error,
  output uart_pkg::seg_t seg_ones,
  output uart_pkg::seg_t seg_tens,
  output uart_pkg::seg_t seg_hundreds
);

  import uart_pkg::*;

  logic [11:0] bcd;

  // double dabble, add 3 before each shift
  function automatic logic [11:0] to_bcd(input logic [7:0] bin);
    logic [11:0] acc;
    acc = '0;
    for (int i = 7; i >= 0; i--)
    begin
      if (acc[3:0] > 4'd4)
        acc[3:0] = acc[3:0] + 4'd3;
      if (acc[7:4] > 4'd4)
        acc[7:4] = acc[7:4] + 4'd3;
      acc = {acc[10:0], bin[i]};
    end
    return acc;
  endfunction

  function automatic seg_t to_seg(input logic [3:0] digit);
    case (digit)
      4'd1:    return 7'b0110000;
      4'd2:    return 7'b1101101;
      4'd3:    return 7'b1111001;
      4'd4:    return 7'b0110011;
      4'd5:    return 7'b1011011;
      4'd6:    return 7'b0011111;
      4'd7:    return 7'b1110000;
      4'd8:    return 7'b1111111;
      4'd9:    return 7'b1111011;
      default: return 7'b1111110;  // 0 and out of range
    endcase
  endfunction

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rx_data      <= '0;
      parity_error <= 1'b0;
      stop_error   <= 1'b0;
    end
    else if (frame.valid)
    begin
      rx_data      <= frame.data;
      parity_error <= frame.parity_error;
      stop_error   <= frame.stop_error;
    end
  end

  always_comb
  begin
    bcd          = to_bcd(rx_data);
    seg_ones     = to_seg(bcd[3:0]);
    seg_tens     = to_seg(bcd[7:4]);
    seg_hundreds = to_seg(bcd[11:8]);
  end

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 os_tick,
  input  uart_pkg::frame_cfg_t cfg,
  input  logic                 serial_line,
  output logic                 rx_busy,
  rx_frame_if.source           frame
);

  import uart_pkg::*;

  localparam int TW = $clog2(OVERSAMPLE);
  localparam logic [TW-1:0] LAST_TICK = TW'(OVERSAMPLE - 1);
  localparam logic [TW-1:0] MID_TICK  = TW'(MID_SAMPLE - 1);

  typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_e;

  state_e        state;
  logic [TW-1:0] tick_cnt;
  logic [2:0]    bit_idx;
  logic          stop_idx;
  logic          par_acc;
  logic [7:0]    data_r;
  logic          par_err_r;
  logic          stop_err_r;
  logic          valid_r;
  logic          bit_end;
  logic          start_ok;
  logic [2:0]    last_idx;

  assign bit_end  = os_tick && (tick_cnt == LAST_TICK);
  assign start_ok = os_tick && (state == START) && (tick_cnt == MID_TICK) && !serial_line;
  assign last_idx = cfg.data_bits8 ? 3'd7 : 3'd6;
  assign rx_busy  = (state != IDLE);

  assign frame.data         = data_r;
  assign frame.valid        = valid_r;
  assign frame.parity_error = par_err_r;
  assign frame.stop_error   = stop_err_r;

  // cleared per frame so bit 7 reads 0 in 7-bit mode
  always_ff @(posedge clk)
  begin
    if (start_ok)
      data_r <= '0;
    else if (bit_end && state == DATA)
      data_r[bit_idx] <= serial_line;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= IDLE;
      tick_cnt   <= '0;
      bit_idx    <= '0;
      stop_idx   <= 1'b0;
      par_acc    <= 1'b0;
      par_err_r  <= 1'b0;
      stop_err_r <= 1'b0;
      valid_r    <= 1'b0;
    end
    else
    begin
      valid_r <= 1'b0;
      if (os_tick)
      begin
        case (state)
          IDLE:
          begin
            if (!serial_line)
            begin
              state    <= START;
              tick_cnt <= TW'(1);  // this tick counts
            end
          end
          START:
          begin
            if (tick_cnt != MID_TICK)
              tick_cnt <= tick_cnt + 1'b1;
            else if (start_ok)
            begin
              state      <= DATA;
              tick_cnt   <= '0;
              bit_idx    <= '0;
              par_acc    <= 1'b0;
              par_err_r  <= 1'b0;
              stop_err_r <= 1'b0;
            end
            else
              state <= IDLE;  // glitch, not a start bit
          end
          default:
          begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            if (bit_end)
            begin
              if (state == DATA)
              begin
                par_acc <= par_acc ^ serial_line;
                bit_idx <= bit_idx + 3'd1;
                if (bit_idx == last_idx)
                begin
                  state    <= (cfg.parity != PAR_NONE) ? PARITY : STOP;
                  stop_idx <= 1'b0;
                end
              end
              else if (state == PARITY)
              begin
                par_err_r <= (par_acc ^ serial_line) != (cfg.parity == PAR_ODD);
                state     <= STOP;
              end
              else
              begin
                stop_err_r <= stop_err_r | ~serial_line;
                if (cfg.two_stop && !stop_idx)
                  stop_idx <= 1'b1;
                else
                begin
                  state   <= IDLE;  // report at mid of last stop bit
                  valid_r <= 1'b1;
                end
              end
            end
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

module uart_tx (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 os_tick,
  input  uart_pkg::frame_cfg_t cfg,
  input  logic                 tx_req,
  input  logic [7:0]           tx_data,
  output logic                 tx_ack,
  output logic                 tx_busy,
  output logic                 serial_line
);

  import uart_pkg::*;

  localparam int TW = $clog2(OVERSAMPLE);
  localparam logic [TW-1:0] LAST_TICK = TW'(OVERSAMPLE - 1);

  typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_e;

  state_e        state;
  logic [TW-1:0] tick_cnt;
  logic [2:0]    bit_idx;
  logic          stop_idx;
  logic [7:0]    data_r;
  logic          take;
  logic          bit_end;
  logic [2:0]    last_idx;
  logic          par_bit;

  assign take     = (state == IDLE) && tx_req && !tx_ack;
  assign bit_end  = os_tick && (tick_cnt == LAST_TICK);
  assign last_idx = cfg.data_bits8 ? 3'd7 : 3'd6;
  assign tx_busy  = (state != IDLE);
  // odd parity inverts the plain xor of the data bits
  assign par_bit  = ^{cfg.data_bits8 & data_r[7], data_r[6:0]} ^ (cfg.parity == PAR_ODD);

  always_ff @(posedge clk)
  begin
    if (take)
      data_r <= tx_data;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= IDLE;
      tick_cnt    <= '0;
      bit_idx     <= '0;
      stop_idx    <= 1'b0;
      tx_ack      <= 1'b0;
      serial_line <= 1'b1;
    end
    else
    begin
      if (take)
        tx_ack <= 1'b1;
      else if (!tx_req)
        tx_ack <= 1'b0;

      if (take)
      begin
        state       <= START;  // start bit begins with the ack
        serial_line <= 1'b0;
        tick_cnt    <= '0;
      end
      else if (state != IDLE && os_tick)
      begin
        tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
        if (bit_end)
        begin
          case (state)
            START:
            begin
              state       <= DATA;
              bit_idx     <= '0;
              serial_line <= data_r[0];
            end
            DATA:
            begin
              if (bit_idx != last_idx)
              begin
                bit_idx     <= bit_idx + 3'd1;
                serial_line <= data_r[bit_idx + 3'd1];
              end
              else if (cfg.parity != PAR_NONE)
              begin
                state       <= PARITY;
                serial_line <= par_bit;
              end
              else
              begin
                state       <= STOP;
                stop_idx    <= 1'b0;
                serial_line <= 1'b1;
              end
            end
            PARITY:
            begin
              state       <= STOP;
              stop_idx    <= 1'b0;
              serial_line <= 1'b1;
            end
            default:
            begin
              if (cfg.two_stop && !stop_idx)
                stop_idx <= 1'b1;
              else
                state <= IDLE;
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: line_config.sv
`default_nettype none

module line_config (
  input  logic                clk,
  input  logic                reset,
  input  logic                data_bits8,
  input  uart_pkg::parity_e   parity_mode,
  input  logic                two_stop,
  input  logic                tx_busy,
  input  logic                rx_busy,
  output uart_pkg::frame_cfg_t cfg
);

  import uart_pkg::*;

  // format only moves between frames, never inside one
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      cfg.data_bits8 <= 1'b1;
      cfg.parity     <= PAR_NONE;
      cfg.two_stop   <= 1'b0;
    end
    else if (!tx_busy && !rx_busy)
    begin
      cfg.data_bits8 <= data_bits8;
      cfg.parity     <= parity_mode;
      cfg.two_stop   <= two_stop;
    end
  end

endmodule

`default_nettype wire

// File: baud_gen.sv
`default_nettype none

module baud_gen #(
  parameter int CLKS_PER_TICK = 4
) (
  input  logic clk,
  input  logic reset,
  output logic os_tick
);

  localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
  localparam logic [CW-1:0] LAST = CW'(CLKS_PER_TICK - 1);

  logic [CW-1:0] count;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count   <= '0;
      os_tick <= 1'b0;
    end
    else
    begin
      os_tick <= (count == LAST);
      count   <= (count == LAST) ? '0 : count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rx_frame_if.sv
`default_nettype none

interface rx_frame_if;
  logic [7:0] data;
  logic       valid;  // one-cycle pulse at end of frame
  logic       parity_error;
  logic       stop_error;

  modport source (output data, output valid, output parity_error, output stop_error);

  modport sink (input data, input valid, input parity_error, input stop_error);

endinterface

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

  typedef enum logic [1:0]
  {
    PAR_NONE = 2'd0,
    PAR_ODD  = 2'd1,
    PAR_EVEN = 2'd2
  } parity_e;

  // 4 bits in total
  typedef struct packed
  {
    logic    data_bits8;  // 0 selects 7 data bits
    parity_e parity;
    logic    two_stop;
  } frame_cfg_t;

  // segments a..g on bits 6..0, active high
  typedef logic [6:0] seg_t;

  localparam int OVERSAMPLE = 16;  // ticks per bit
  localparam int MID_SAMPLE = 8;   // sample point inside a bit

endpackage

`default_nettype wire
